// File: hw/decodePkg.sv
package decodePkg;

    // instruction word layout
    localparam int INSTR_WIDTH = 32;
    localparam int OPCODE_MSB  = 31;
    localparam int OPCODE_LSB  = 26;
    localparam int RS_MSB      = 25;
    localparam int RS_LSB      = 21;
    localparam int FUNCT_MSB   = 5;
    localparam int FUNCT_LSB   = 0;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'd0;  // funct selects the op
    localparam logic [5:0] OP_JAL   = 6'd3;
    localparam logic [5:0] OP_BEQ   = 6'd4;
    localparam logic [5:0] OP_BNE   = 6'd5;
    localparam logic [5:0] OP_ADDI  = 6'd8;
    localparam logic [5:0] OP_ANDI  = 6'd12;
    localparam logic [5:0] OP_ORI   = 6'd13;
    localparam logic [5:0] OP_LUI   = 6'd15;
    localparam logic [5:0] OP_COP0  = 6'd16; // not supported, decodes as nop
    localparam logic [5:0] OP_LB    = 6'd32;
    localparam logic [5:0] OP_LH    = 6'd33;
    localparam logic [5:0] OP_LW    = 6'd35;
    localparam logic [5:0] OP_SB    = 6'd40;
    localparam logic [5:0] OP_SH    = 6'd41;
    localparam logic [5:0] OP_SW    = 6'd43;

    // rs sub-codes under the cop0 opcode
    localparam logic [4:0] RS_MFC0 = 5'd0;
    localparam logic [4:0] RS_MTC0 = 5'd4;

    // funct codes, valid only with OP_RTYPE
    localparam logic [5:0] FN_JR    = 6'd8;
    localparam logic [5:0] FN_MFHI  = 6'd16;
    localparam logic [5:0] FN_MTHI  = 6'd17;
    localparam logic [5:0] FN_MFLO  = 6'd18;
    localparam logic [5:0] FN_MTLO  = 6'd19;
    localparam logic [5:0] FN_MULT  = 6'd24;
    localparam logic [5:0] FN_MULTU = 6'd25;
    localparam logic [5:0] FN_DIV   = 6'd26;
    localparam logic [5:0] FN_DIVU  = 6'd27;
    localparam logic [5:0] FN_ADD   = 6'd32;
    localparam logic [5:0] FN_SUB   = 6'd34;
    localparam logic [5:0] FN_AND   = 6'd36;
    localparam logic [5:0] FN_OR    = 6'd37;
    localparam logic [5:0] FN_SLT   = 6'd42;
    localparam logic [5:0] FN_SLTU  = 6'd43;

    // decoded instruction kind, nop is zero so a cleared word reads as nop
    typedef enum logic [4:0] {
        KIND_NOP   = 5'd0,
        KIND_ADD   = 5'd1,
        KIND_SUB   = 5'd2,
        KIND_AND   = 5'd3,
        KIND_OR    = 5'd4,
        KIND_SLT   = 5'd5,
        KIND_SLTU  = 5'd6,
        KIND_ORI   = 5'd7,
        KIND_ANDI  = 5'd8,
        KIND_ADDI  = 5'd9,
        KIND_LUI   = 5'd10,
        KIND_LW    = 5'd11,
        KIND_LH    = 5'd12,
        KIND_LB    = 5'd13,
        KIND_SW    = 5'd14,
        KIND_SH    = 5'd15,
        KIND_SB    = 5'd16,
        KIND_BEQ   = 5'd17,
        KIND_BNE   = 5'd18,
        KIND_JR    = 5'd19,
        KIND_JAL   = 5'd20,
        KIND_MULT  = 5'd21,
        KIND_MULTU = 5'd22,
        KIND_DIV   = 5'd23,
        KIND_DIVU  = 5'd24,
        KIND_MFLO  = 5'd25,
        KIND_MFHI  = 5'd26,
        KIND_MTLO  = 5'd27,
        KIND_MTHI  = 5'd28
    } instrKind_e;

    // alu operation codes as the execute stage expects them
    typedef enum logic [4:0] {
        ALU_SUB  = 5'd0,
        ALU_ADD  = 5'd1,
        ALU_OR   = 5'd2,
        ALU_LUI  = 5'd3,  // imm << 16
        ALU_AND  = 5'd4,
        ALU_SLT  = 5'd5,
        ALU_SLTU = 5'd6
    } aluOp_e;

    typedef logic [1:0] stageCount_t; // pipeline stage distance

    // datapath controls, 11 bits
    typedef struct packed {
        logic   memToReg;   // 1: alu result, 0: memory or other source
        logic   memWrite;
        aluOp_e aluOp;
        logic   aluSrc;     // 1: immediate operand
        logic   regDst;     // 1: rd field, 0: rt field
        logic   regWriteEn;
        logic   signExt;    // 1: sign-extend imm16
    } ctrlSig_t;

    // stall logic inputs, 8 bits
    typedef struct packed {
        stageCount_t tuseRs; // stages until rs is needed
        stageCount_t tuseRt; // stages until rt is needed
        stageCount_t eTnew;  // result latency seen from execute
        stageCount_t mTnew;  // result latency seen from memory
    } hazardTiming_t;

endpackage

// File: hw/instrClassify.sv
`timescale 1ns/1ns

module instrClassify import decodePkg::*; (
    input  logic [INSTR_WIDTH-1:0] instr,
    output instrKind_e             kind
);

    logic [OPCODE_MSB-OPCODE_LSB:0] opcode;
    logic [FUNCT_MSB-FUNCT_LSB:0]   funct;

    assign opcode = instr[OPCODE_MSB:OPCODE_LSB];
    assign funct  = instr[FUNCT_MSB:FUNCT_LSB];

    always_comb begin
        kind = KIND_NOP; // unmatched words fall through as nop
        if (opcode == OP_RTYPE) begin
            // all-zero word lands here with funct 0 and stays nop
            case (funct)
                FN_ADD:   kind = KIND_ADD;
                FN_SUB:   kind = KIND_SUB;
                FN_AND:   kind = KIND_AND;
                FN_OR:    kind = KIND_OR;
                FN_SLT:   kind = KIND_SLT;
                FN_SLTU:  kind = KIND_SLTU;
                FN_JR:    kind = KIND_JR;
                FN_MULT:  kind = KIND_MULT;
                FN_MULTU: kind = KIND_MULTU;
                FN_DIV:   kind = KIND_DIV;
                FN_DIVU:  kind = KIND_DIVU;
                FN_MFLO:  kind = KIND_MFLO;
                FN_MFHI:  kind = KIND_MFHI;
                FN_MTLO:  kind = KIND_MTLO;
                FN_MTHI:  kind = KIND_MTHI;
                default:  kind = KIND_NOP; // shifts, syscall, etc
            endcase
        end else begin
            case (opcode)
                OP_ORI:  kind = KIND_ORI;
                OP_ANDI: kind = KIND_ANDI;
                OP_ADDI: kind = KIND_ADDI;
                OP_LUI:  kind = KIND_LUI;
                OP_LW:   kind = KIND_LW;
                OP_LH:   kind = KIND_LH;
                OP_LB:   kind = KIND_LB;
                OP_SW:   kind = KIND_SW;
                OP_SH:   kind = KIND_SH;
                OP_SB:   kind = KIND_SB;
                OP_BEQ:  kind = KIND_BEQ;
                OP_BNE:  kind = KIND_BNE;
                OP_JAL:  kind = KIND_JAL;
                default: kind = KIND_NOP; // cop0 and unused opcodes
            endcase
        end
    end

endmodule

// File: hw/ctrlSignalTable.sv
`timescale 1ns/1ns

module ctrlSignalTable import decodePkg::*; (
    input  instrKind_e kind,
    output ctrlSig_t   ctrl
);

    always_comb begin
        case (kind)
            // register alu ops, write rd with the alu result
            KIND_ADD: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_ADD, aluSrc: 1'b0,
                               regDst: 1'b1, regWriteEn: 1'b1, signExt: 1'b0};
            KIND_SUB: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_SUB, aluSrc: 1'b0,
                               regDst: 1'b1, regWriteEn: 1'b1, signExt: 1'b0};
            KIND_AND: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_AND, aluSrc: 1'b0,
                               regDst: 1'b1, regWriteEn: 1'b1, signExt: 1'b0};
            KIND_OR: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_OR, aluSrc: 1'b0,
                              regDst: 1'b1, regWriteEn: 1'b1, signExt: 1'b0};
            KIND_SLT: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_SLT, aluSrc: 1'b0,
                               regDst: 1'b1, regWriteEn: 1'b1, signExt: 1'b0};
            KIND_SLTU: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_SLTU, aluSrc: 1'b0,
                                regDst: 1'b1, regWriteEn: 1'b1, signExt: 1'b0};

            // immediate alu ops write rt
            KIND_ORI: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_OR, aluSrc: 1'b1,
                               regDst: 1'b0, regWriteEn: 1'b1, signExt: 1'b0}; // zero-ext
            KIND_ANDI: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_AND, aluSrc: 1'b1,
                                regDst: 1'b0, regWriteEn: 1'b1, signExt: 1'b0}; // zero-ext
            KIND_ADDI: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_ADD, aluSrc: 1'b1,
                                regDst: 1'b0, regWriteEn: 1'b1, signExt: 1'b1};
            KIND_LUI: ctrl = '{memToReg: 1'b1, memWrite: 1'b0, aluOp: ALU_LUI, aluSrc: 1'b1,
                               regDst: 1'b0, regWriteEn: 1'b1, signExt: 1'b0};

            // address = rs + sext(imm16)
            KIND_LW, KIND_LH, KIND_LB: begin
                ctrl = '{memToReg: 1'b0, memWrite: 1'b0, aluOp: ALU_ADD, aluSrc: 1'b1,
                         regDst: 1'b0, regWriteEn: 1'b1, signExt: 1'b1}; // data from memory
            end
            KIND_SW, KIND_SH, KIND_SB: begin
                ctrl = '{memToReg: 1'b0, memWrite: 1'b1, aluOp: ALU_ADD, aluSrc: 1'b1,
                         regDst: 1'b0, regWriteEn: 1'b0, signExt: 1'b1};
            end

            // compare by subtraction, offset sign-extended
            KIND_BEQ, KIND_BNE: begin
                ctrl = '{memToReg: 1'b0, memWrite: 1'b0, aluOp: ALU_SUB, aluSrc: 1'b0,
                         regDst: 1'b0, regWriteEn: 1'b0, signExt: 1'b1};
            end

            // pc+8 into $31, link path picks the source
            KIND_JAL: ctrl = '{memToReg: 1'b0, memWrite: 1'b0, aluOp: ALU_SUB, aluSrc: 1'b0,
                               regDst: 1'b0, regWriteEn: 1'b1, signExt: 1'b0};

            // hi/lo value into rd
            KIND_MFLO, KIND_MFHI: begin
                ctrl = '{memToReg: 1'b0, memWrite: 1'b0, aluOp: ALU_SUB, aluSrc: 1'b0,
                         regDst: 1'b1, regWriteEn: 1'b1, signExt: 1'b0};
            end

            // jr, mult/div, mtlo/mthi and nop touch no gpr
            default: ctrl = '{memToReg: 1'b0, memWrite: 1'b0, aluOp: ALU_SUB, aluSrc: 1'b0,
                              regDst: 1'b0, regWriteEn: 1'b0, signExt: 1'b0};
        endcase
    end

endmodule

// File: hw/hazardTimingTable.sv
`timescale 1ns/1ns

module hazardTimingTable import decodePkg::*; (
    input  instrKind_e    kind,
    output hazardTiming_t timing
);

    // tuse = stages after decode before the operand is consumed (3 = never)
    // tnew = stages until the written value can be forwarded
    always_comb begin
        case (kind)
            KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_SLT, KIND_SLTU: begin
                timing = '{tuseRs: 2'd1, tuseRt: 2'd1, eTnew: 2'd1, mTnew: 2'd0};
            end
            KIND_ORI, KIND_ANDI, KIND_ADDI: begin
                timing = '{tuseRs: 2'd1, tuseRt: 2'd3, eTnew: 2'd1, mTnew: 2'd0};
            end
            KIND_LUI: begin
                timing = '{tuseRs: 2'd3, tuseRt: 2'd3, eTnew: 2'd1, mTnew: 2'd0}; // no reg read
            end
            KIND_LW, KIND_LH, KIND_LB: begin
                timing = '{tuseRs: 2'd1, tuseRt: 2'd3, eTnew: 2'd2, mTnew: 2'd1};
            end
            KIND_SW, KIND_SH, KIND_SB: begin
                // store data only needed in the memory stage
                timing = '{tuseRs: 2'd1, tuseRt: 2'd2, eTnew: 2'd0, mTnew: 2'd0};
            end
            KIND_BEQ, KIND_BNE: begin
                timing = '{tuseRs: 2'd0, tuseRt: 2'd0, eTnew: 2'd0, mTnew: 2'd0}; // compare in D
            end
            KIND_JR: begin
                timing = '{tuseRs: 2'd0, tuseRt: 2'd3, eTnew: 2'd0, mTnew: 2'd0}; // target in D
            end
            KIND_JAL: begin
                timing = '{tuseRs: 2'd3, tuseRt: 2'd3, eTnew: 2'd2, mTnew: 2'd1};
            end
            KIND_MULT, KIND_MULTU, KIND_DIV, KIND_DIVU: begin
                timing = '{tuseRs: 2'd1, tuseRt: 2'd1, eTnew: 2'd0, mTnew: 2'd0}; // hi/lo only
            end
            KIND_MFLO, KIND_MFHI: begin
                timing = '{tuseRs: 2'd3, tuseRt: 2'd3, eTnew: 2'd2, mTnew: 2'd1};
            end
            KIND_MTLO, KIND_MTHI: begin
                timing = '{tuseRs: 2'd1, tuseRt: 2'd0, eTnew: 2'd0, mTnew: 2'd0};
            end
            default: begin
                // nop never stalls anyone
                timing = '{tuseRs: 2'd3, tuseRt: 2'd3, eTnew: 2'd0, mTnew: 2'd0};
            end
        endcase
    end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ns

module controlUnit import decodePkg::*; (
    input  logic [INSTR_WIDTH-1:0] instr,
    output instrKind_e             kind,
    output ctrlSig_t               ctrl,
    output hazardTiming_t          timing
);

    // word -> kind, then both tables key off kind
    instrClassify classifyInst (
        .instr (instr),
        .kind  (kind)
    );

    ctrlSignalTable ctrlInst (
        .kind (kind),
        .ctrl (ctrl)   // to datapath muxes
    );

    hazardTimingTable timingInst (
        .kind   (kind),
        .timing (timing) // to stall compare
    );

endmodule

// File: tests/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected kind from the raw opcode and funct numbers
function automatic instrKind_e modelKind(input logic [31:0] word);
    logic [5:0] op;
    logic [5:0] fn;
    instrKind_e k;
    op = word[31:26];
    fn = word[5:0];
    k = KIND_NOP;
    if (op == 6'd0) begin
        case (fn)
            6'd8:    k = KIND_JR;
            6'd16:   k = KIND_MFHI;
            6'd17:   k = KIND_MTHI;
            6'd18:   k = KIND_MFLO;
            6'd19:   k = KIND_MTLO;
            6'd24:   k = KIND_MULT;
            6'd25:   k = KIND_MULTU;
            6'd26:   k = KIND_DIV;
            6'd27:   k = KIND_DIVU;
            6'd32:   k = KIND_ADD;
            6'd34:   k = KIND_SUB;
            6'd36:   k = KIND_AND;
            6'd37:   k = KIND_OR;
            6'd42:   k = KIND_SLT;
            6'd43:   k = KIND_SLTU;
            default: k = KIND_NOP;
        endcase
    end else begin
        case (op)
            6'd3:    k = KIND_JAL;
            6'd4:    k = KIND_BEQ;
            6'd5:    k = KIND_BNE;
            6'd8:    k = KIND_ADDI;
            6'd12:   k = KIND_ANDI;
            6'd13:   k = KIND_ORI;
            6'd15:   k = KIND_LUI;
            6'd32:   k = KIND_LB;
            6'd33:   k = KIND_LH;
            6'd35:   k = KIND_LW;
            6'd40:   k = KIND_SB;
            6'd41:   k = KIND_SH;
            6'd43:   k = KIND_SW;
            default: k = KIND_NOP; // cop0 and everything else
        endcase
    end
    return k;
endfunction

// fields start cleared, each group sets only what it needs
function automatic ctrlSig_t modelCtrl(input instrKind_e k);
    ctrlSig_t c;
    c = '0;
    case (k)
        KIND_ADD, KIND_ADDI, KIND_LW, KIND_LH, KIND_LB, KIND_SW, KIND_SH, KIND_SB:
            c.aluOp = ALU_ADD;
        KIND_AND, KIND_ANDI: c.aluOp = ALU_AND;
        KIND_OR, KIND_ORI:   c.aluOp = ALU_OR;
        KIND_SLT:            c.aluOp = ALU_SLT;
        KIND_SLTU:           c.aluOp = ALU_SLTU;
        KIND_LUI:            c.aluOp = ALU_LUI;
        default:             c.aluOp = ALU_SUB; // code 0, also branches
    endcase
    case (k)
        KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_SLT, KIND_SLTU: begin
            c.memToReg = 1'b1;
            c.regDst = 1'b1;
            c.regWriteEn = 1'b1;
        end
        KIND_ORI, KIND_ANDI, KIND_ADDI, KIND_LUI: begin
            c.aluSrc = 1'b1;
            c.memToReg = 1'b1;
            c.regWriteEn = 1'b1;
            c.signExt = (k == KIND_ADDI); // only addi sign-extends
        end
        KIND_LW, KIND_LH, KIND_LB: begin
            c.aluSrc = 1'b1;
            c.signExt = 1'b1;
            c.regWriteEn = 1'b1;
        end
        KIND_SW, KIND_SH, KIND_SB: begin
            c.aluSrc = 1'b1;
            c.signExt = 1'b1;
            c.memWrite = 1'b1;
        end
        KIND_BEQ, KIND_BNE: c.signExt = 1'b1;
        KIND_JAL:           c.regWriteEn = 1'b1;
        KIND_MFLO, KIND_MFHI: begin
            c.regDst = 1'b1;
            c.regWriteEn = 1'b1;
        end
        default: c.memWrite = 1'b0; // nothing set
    endcase
    return c;
endfunction

function automatic hazardTiming_t timingOf(input stageCount_t rs, input stageCount_t rt,
                                           input stageCount_t e, input stageCount_t m);
    hazardTiming_t t;
    t.tuseRs = rs;
    t.tuseRt = rt;
    t.eTnew = e;
    t.mTnew = m;
    return t;
endfunction

function automatic hazardTiming_t modelTiming(input instrKind_e k);
    case (k)
        KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_SLT, KIND_SLTU:
            return timingOf(2'd1, 2'd1, 2'd1, 2'd0);
        KIND_ORI, KIND_ANDI, KIND_ADDI: return timingOf(2'd1, 2'd3, 2'd1, 2'd0);
        KIND_LUI:                       return timingOf(2'd3, 2'd3, 2'd1, 2'd0);
        KIND_LW, KIND_LH, KIND_LB:      return timingOf(2'd1, 2'd3, 2'd2, 2'd1);
        KIND_SW, KIND_SH, KIND_SB:      return timingOf(2'd1, 2'd2, 2'd0, 2'd0);
        KIND_BEQ, KIND_BNE:             return timingOf(2'd0, 2'd0, 2'd0, 2'd0);
        KIND_JR:                        return timingOf(2'd0, 2'd3, 2'd0, 2'd0);
        KIND_JAL, KIND_MFLO, KIND_MFHI: return timingOf(2'd3, 2'd3, 2'd2, 2'd1);
        KIND_MULT, KIND_MULTU, KIND_DIV, KIND_DIVU:
            return timingOf(2'd1, 2'd1, 2'd0, 2'd0);
        KIND_MTLO, KIND_MTHI:           return timingOf(2'd1, 2'd0, 2'd0, 2'd0);
        default:                        return timingOf(2'd3, 2'd3, 2'd0, 2'd0); // nop
    endcase
endfunction

`endif

// File: tests/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb import decodePkg::*; ();

    localparam int NUM_VECTORS    = 2000;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 2100; // vectors + reset + margin

    logic clk;
    logic rst;
    logic [31:0] instr;

    instrKind_e    kind;
    ctrlSig_t      ctrl;
    hazardTiming_t timing;

    int cycleCount = 0;

    // kept encodings for the directed half of the vectors
    logic [5:0] keptOpcodes [0:12] = '{
        6'd3, 6'd4, 6'd5, 6'd8, 6'd12, 6'd13, 6'd15,
        6'd32, 6'd33, 6'd35, 6'd40, 6'd41, 6'd43
    };
    logic [5:0] keptFuncts [0:14] = '{
        6'd8, 6'd16, 6'd17, 6'd18, 6'd19, 6'd24, 6'd25, 6'd26,
        6'd27, 6'd32, 6'd34, 6'd36, 6'd37, 6'd42, 6'd43
    };

    controlUnit controlUnit_inst (
        .instr  (instr),
        .kind   (kind),
        .ctrl   (ctrl),
        .timing (timing)
    );

    `include "decodeModel.svh"

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h (instr 0x%08h)",
                     name, expected, actual, instr);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkOutputs();
        instrKind_e kindExp;
        kindExp = modelKind(instr);
        checkValue("kind", {27'd0, kindExp}, {27'd0, kind});
        checkValue("ctrl", {21'd0, modelCtrl(kindExp)}, {21'd0, ctrl});
        checkValue("timing", {24'd0, modelTiming(kindExp)}, {24'd0, timing});
        if (rst) begin
            checkValue("ctrl in reset", 32'd0, {21'd0, ctrl});
        end
    endtask

    // half directed on a kept opcode or funct, half fully random
    function automatic logic [31:0] randomVector(input bit directed);
        logic [31:0] word;
        int pick;
        word = $urandom;
        if (directed) begin
            if ($urandom % 2 == 0) begin
                pick = $urandom % 15;
                word[31:26] = 6'd0;
                word[5:0] = keptFuncts[pick];
            end else begin
                pick = $urandom % 13;
                word[31:26] = keptOpcodes[pick];
            end
        end
        return word;
    endfunction

    initial begin
        void'($urandom(32'h762)); // single seed for the whole run
        clk = 1'b0;
        rst = 1'b1;
        instr = '0;

        // zero word during reset must read as nop with all controls low
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            checkOutputs();
        end

        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (i > 0) begin
                @(posedge clk);
            end
            instr <= randomVector(i % 2 == 0);
            @(negedge clk); // outputs settled half a cycle later
            checkOutputs();
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: files.f
+incdir+tests
hw/decodePkg.sv
hw/instrClassify.sv
hw/ctrlSignalTable.sv
hw/hazardTimingTable.sv
hw/controlUnit.sv
tests/controlUnitTb.sv

// File: run.sh
#!/bin/sh
# build the decoder testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    -f files.f \
    --top-module controlUnitTb \
    -o controlUnitTbSim

# exit status is nonzero on any $fatal
./obj_dir/controlUnitTbSim
